/* project.f */
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/rename_ctrl.sv
src/rename_top.sv
sim/rename_properties.sv
sim/rename_checker.sv
sim/rename_tb.sv

/* run.sh */
#!/bin/sh
# Compile the rename stage testbench with Verilator, run it, and check the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module rename_tb -f project.f &&
./obj_dir/Vrename_tb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/rename_checker.sv */
/*
 * Response checker for the rename testbench. Compares rsp_o with the
 * expected response each time ack_o rises, counts the responses, and
 * flags any change of rsp_o while ack_o stays high.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_checker import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         ack_i,
  input  rename_rsp_t rsp_i,
  input  rename_rsp_t exp_i,     // Held by the testbench for the whole handshake.
  output int          errors_o,
  output int          acks_o
);

  logic        ack_q = 1'b0;
  rename_rsp_t rsp_q;            // Response seen on the previous edge.
  int          errors = 0;
  int          acks   = 0;

  assign errors_o = errors;
  assign acks_o   = acks;

  task automatic check_field(input string name, input logic [5:0] got, input logic [5:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    // Rising ack, response registered one edge ago.
    if (!rst && ack_i && !ack_q) begin
      acks++;
      check_field("opa_preg", rsp_i.opa_preg, exp_i.opa_preg);
      check_field("opa_rdy", {5'b0, rsp_i.opa_rdy}, {5'b0, exp_i.opa_rdy});
      check_field("opb_preg", rsp_i.opb_preg, exp_i.opb_preg);
      check_field("opb_rdy", {5'b0, rsp_i.opb_rdy}, {5'b0, exp_i.opb_rdy});
      check_field("dest_preg", rsp_i.dest_preg, exp_i.dest_preg);
      check_field("old_preg", rsp_i.old_preg, exp_i.old_preg);
    end
    if (!rst && ack_i && ack_q && rsp_i !== rsp_q) begin
      $display("ERR rsp_o changed while ack_o high: %h now %h", rsp_q, rsp_i);
      errors++;
    end
    ack_q <= ack_i;
    rsp_q <= rsp_i;
  end

endmodule

`default_nettype wire

/* sim/rename_patterns.txt */
// Kind(D dispatch, C wakeup, F retire) Flag Rep _ opa opb dest _ opa_preg rdy opb_preg rdy
// dest_preg old_preg. C and F carry the preg in the last field; flag 1 ties them to next D.
D0_01_01_02_03_01_1_02_1_20_03 // Reset map, first allocation.
D0_01_03_00_04_20_0_00_1_21_04 // Renamed areg 3 reads back not ready.
C0_00_00_00_00_00_0_00_0_00_20
D0_01_03_04_00_20_1_21_0_00_00 // No destination, nothing popped.
C1_00_00_00_00_00_0_00_0_00_21
D0_01_04_05_05_21_1_05_1_22_05 // Same-cycle wakeup bypass.
D0_01_04_05_06_21_1_22_0_23_06
D0_1C_00_00_07_00_1_00_1_24_07 // Drain the free list.
F1_00_00_00_00_00_0_00_0_00_07
D0_01_07_03_08_3F_0_20_1_07_08 // Stalls until the retire.
F0_00_00_00_00_00_0_00_0_00_08
C1_00_00_00_00_00_0_00_0_00_07
D0_01_08_09_08_07_1_09_1_08_07 // Wakeup and write of one entry.
D0_01_08_00_00_08_0_00_1_00_00 // Write won, not ready.
00_00_00_00_00_00_0_00_0_00_00

/* sim/rename_properties.sv */
/*
 * Handshake assertions for the rename controller.
 * Bound into every rename_ctrl instance.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_properties (
  input wire clk,
  input wire rst,
  input wire req_i,
  input wire ack_i,
  input wire wr_en_i,
  input wire pop_i,
  input wire empty_i
);

  // Ack only answers a request.
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose without req_i");

  ack_held: assert property (@(posedge clk) disable iff (rst)
    (ack_i && req_i) |=> ack_i)
    else $error("ack_o dropped while req_i was high");

  // Every map write consumes a real free-list entry.
  write_pops: assert property (@(posedge clk) disable iff (rst)
    wr_en_i |-> (pop_i && !empty_i))
    else $error("wr_en_o without a pop of a nonempty free list");

endmodule

bind rename_ctrl rename_properties u_props (
  .clk     (clk),
  .rst     (rst),
  .req_i   (req_i),
  .ack_i   (ack_o),
  .wr_en_i (wr_en_o),
  .pop_i   (pop_o),
  .empty_i (empty_i)
);

`default_nettype wire

/* sim/rename_tb.sv */
/*
 * Testbench for the rename stage. Replays sim/rename_patterns.txt over the
 * req/ack handshake, with LFSR idle gaps and req hold times, and prints the
 * closing report. Response comparison is done in rename_checker.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

  localparam int MAX_LINES  = 64;
  localparam int WAIT_LIMIT = 100;  // Cycles before a wait gives up.

  logic        clk = 1'b0;
  logic        rst;
  logic        req;
  rename_req_t req_data;
  preg_bcast_t cdb;
  preg_bcast_t retire;
  logic        ack;
  rename_rsp_t rsp;
  rename_rsp_t expected;             // Response the checker compares against.
  logic [79:0] patterns [MAX_LINES];
  logic [31:0] lfsr = 32'h7b60_d904;
  preg_bcast_t cdb_armed;            // Wakeup held for the next dispatch edge.
  preg_bcast_t retire_armed;         // Retire held until the next dispatch stalls.
  int          tb_errors  = 0;
  int          dispatches = 0;
  int          chk_errors;
  int          acks;

  always #4 clk = ~clk;

  rename_top UUT (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req),
    .req_data_i (req_data),
    .cdb_i      (cdb),
    .retire_i   (retire),
    .ack_o      (ack),
    .rsp_o      (rsp)
  );

  rename_checker u_check (
    .clk      (clk),
    .rst      (rst),
    .ack_i    (ack),
    .rsp_i    (rsp),
    .exp_i    (expected),
    .errors_o (chk_errors),
    .acks_o   (acks)
  );

  // Galois LFSR, right shifting.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (ack !== level) begin
      $display("Timeout: ack_o did not go to %0d within %0d cycles", level, WAIT_LIMIT);
      tb_errors++;
    end
  endtask

  // Full four-phase handshake for one instruction.
  task automatic dispatch(input rename_req_t r, input rename_rsp_t e);
    int hold;
    @(negedge clk);
    req_data  = r;
    expected  = e;
    req       = 1'b1;
    cdb       = cdb_armed;  // Broadcast on the dispatch edge.
    cdb_armed = '0;
    @(negedge clk);
    cdb = '0;
    if (retire_armed.valid) begin
      // Free list is empty, so ack has to wait for the retire.
      repeat (4) begin
        if (ack) begin
          $display("ack_o rose while the free list was empty");
          tb_errors++;
        end
        @(negedge clk);
      end
      retire       = retire_armed;
      retire_armed = '0;
      @(negedge clk);
      retire = '0;
    end
    wait_ack(1'b1);
    dispatches++;
    take_bits(2, hold);
    repeat (hold) @(negedge clk);  // Decoder keeps req up with ack high.
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  initial begin
    logic [79:0] w;
    rename_req_t r;
    rename_rsp_t e;
    preg_bcast_t bc;
    int          gap;
    int          line;
    rst          = 1'b1;
    req          = 1'b0;
    req_data     = '0;
    cdb          = '0;
    retire       = '0;
    expected     = '0;
    cdb_armed    = '0;
    retire_armed = '0;
    for (int i = 0; i < MAX_LINES; i++) begin
      patterns[i] = '0;
    end
    $readmemh("sim/rename_patterns.txt", patterns);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst  = 1'b0;
    line = 0;
    while (line < MAX_LINES && patterns[line][79:76] != 4'h0) begin
      w  = patterns[line];
      bc = '{valid: 1'b1, preg: w[5:0]};
      case (w[79:76])
        4'hD: begin
          r = '{opa_areg: w[60:56], opb_areg: w[52:48], dest_areg: w[44:40]};
          e = '{opa_preg: w[37:32], opa_rdy: w[28], opb_preg: w[25:20], opb_rdy: w[16],
                dest_preg: w[13:8], old_preg: w[5:0]};
          for (int k = 0; k < int'(w[71:64]); k++) begin
            dispatch(r, e);
            e.old_preg  = e.dest_preg;  // Burst keeps renaming the same dest.
            e.dest_preg = e.dest_preg + 1'b1;
            take_bits(2, gap);
            repeat (gap) @(negedge clk);
          end
        end
        4'hC: begin
          if (w[72]) begin
            cdb_armed = bc;
          end else begin
            @(negedge clk);
            cdb = bc;
            @(negedge clk);
            cdb = '0;
          end
        end
        4'hF: begin
          if (w[72]) begin
            retire_armed = bc;
          end else begin
            @(negedge clk);
            retire = bc;
            @(negedge clk);
            retire = '0;
          end
        end
        default: begin
          $display("Unknown operation kind on pattern line %0d", line);
          tb_errors++;
        end
      endcase
      line++;
    end
    repeat (4) @(negedge clk);
    if (dispatches == 0 || acks != dispatches) begin
      $display("Saw %0d responses for %0d dispatches", acks, dispatches);
      tb_errors++;
    end
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/free_list.sv */
/*
 * FIFO of unallocated physical registers.
 * Out of reset it holds pregs 32 to 63 in order. Rename pops the head,
 * retirement pushes a freed preg at the tail. Both can happen in one
 * cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         pop_i,        // Allocation at rename.
  input  preg_bcast_t retire_i,     // Preg freed at retirement.
  output preg_t       head_preg_o,  // Next preg to hand out.
  output logic        empty_o
);

  preg_t                           fifo_q [FREE_DEPTH];
  logic [$clog2(FREE_DEPTH)-1:0]   head_q;   // Read pointer, wraps naturally.
  logic [$clog2(FREE_DEPTH)-1:0]   tail_q;   // Write pointer.
  fl_count_t                       count_q;  // Entries held.
  logic                            do_pop;
  logic                            do_push;

  assign empty_o     = (count_q == '0);
  assign head_preg_o = fifo_q[head_q];

  assign do_pop = pop_i && !empty_o;  // Pop of an empty list is ignored.

  // Pregs are conserved, so a full list plus a push should not occur.
  // A simultaneous pop makes room anyway.
  assign do_push = retire_i.valid &&
                   (do_pop || (count_q != fl_count_t'(FREE_DEPTH)));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(NUM_PREGS - FREE_DEPTH + i);  // Upper half is free.
      end
      head_q  <= '0;
      tail_q  <= '0;                        // Full, so tail meets head.
      count_q <= fl_count_t'(FREE_DEPTH);
    end else begin
      if (do_push) begin
        fifo_q[tail_q] <= retire_i.preg;
        tail_q         <= tail_q + 1'b1;
      end
      if (do_pop) begin
        head_q <= head_q + 1'b1;
      end
      // Occupancy tracks the net change.
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/map_table.sv */
/*
 * Architectural-to-physical register map with per-entry ready bits.
 * Reads are combinational and used at dispatch. A CDB broadcast wakes
 * every entry mapped to the broadcast preg, and the same broadcast is
 * bypassed onto the operand ready outputs in its own cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module map_table import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  areg_t       opa_areg_i,   // Operand A lookup index.
  input  areg_t       opb_areg_i,   // Operand B lookup index.
  input  areg_t       dest_areg_i,  // Destination lookup and write index.
  input  wire         wr_en_i,      // Dispatch write of a new mapping.
  input  preg_t       wr_preg_i,    // New preg from the free-list head.
  input  preg_bcast_t cdb_i,        // Wakeup broadcast.
  output preg_t       opa_preg_o,
  output preg_t       opb_preg_o,
  output preg_t       old_preg_o,   // Current mapping of the destination.
  output logic        opa_rdy_o,
  output logic        opb_rdy_o
);

  preg_t                map_q [NUM_AREGS];  // Current mapping per areg.
  logic [NUM_AREGS-1:0] rdy_q;              // Value of the mapped preg is ready.
  logic [NUM_AREGS-1:0] cdb_hit;            // Entry mapped to the broadcast preg.
  logic                 cdb_live;           // Broadcast counts this cycle.
  logic                 wr_live;            // Write to a real register.

  // Preg 0 backs areg 0 and is always ready, so a broadcast of it is dropped.
  assign cdb_live = cdb_i.valid && (cdb_i.preg != '0);

  // Areg 0 keeps its fixed mapping.
  assign wr_live = wr_en_i && (dest_areg_i != '0);

  // Per-entry match against the CDB tag.
  always_comb begin
    for (int i = 0; i < NUM_AREGS; i++) begin
      cdb_hit[i] = cdb_live && (map_q[i] == cdb_i.preg);
    end
  end

  assign opa_preg_o = map_q[opa_areg_i];
  assign opb_preg_o = map_q[opb_areg_i];
  assign old_preg_o = map_q[dest_areg_i];

  // Same-cycle bypass.
  // A broadcast landing on the dispatch edge still shows up as ready.
  assign opa_rdy_o = rdy_q[opa_areg_i] | cdb_hit[opa_areg_i];
  assign opb_rdy_o = rdy_q[opb_areg_i] | cdb_hit[opb_areg_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        map_q[i] <= preg_t'(i);  // Identity map out of reset.
        rdy_q[i] <= 1'b1;        // All initial values are architectural.
      end
    end else begin
      // Wakeup first.
      for (int i = 0; i < NUM_AREGS; i++) begin
        if (cdb_hit[i]) begin
          rdy_q[i] <= 1'b1;
        end
      end
      // The dispatch write comes later so it overrides a wakeup of the
      // same entry. The new preg has not been produced yet.
      if (wr_live) begin
        map_q[dest_areg_i] <= wr_preg_i;
        rdy_q[dest_areg_i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/rename_ctrl.sv */
/*
 * Rename controller on the decoder's four-phase req/ack handshake.
 * Decides when an instruction may dispatch, strobes the map-table write
 * and free-list pop, and registers the combined rename response, which
 * stays stable while ack is high.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         req_i,        // Decoder request.
  input  rename_req_t req_data_i,   // Held stable while req is high.
  input  preg_t       opa_preg_i,   // Map-table reads.
  input  preg_t       opb_preg_i,
  input  preg_t       old_preg_i,
  input  preg_t       head_preg_i,  // Free-list head.
  input  wire         opa_rdy_i,
  input  wire         opb_rdy_i,
  input  wire         empty_i,      // Free list has nothing to hand out.
  output logic        ack_o,
  output rename_rsp_t rsp_o,
  output logic        wr_en_o,      // Map-table write strobe.
  output preg_t       wr_preg_o,
  output logic        pop_o         // Free-list pop strobe.
);

  ren_state_t  state_q;
  ren_state_t  state_d;
  rename_rsp_t rsp_q;
  logic        dest_live;  // Instruction writes a register.
  logic        can_go;     // Resources available.
  logic        dispatch;   // Rename happens on this edge.

  assign dest_live = (req_data_i.dest_areg != '0);
  assign can_go    = !dest_live || !empty_i;  // No-dest instructions need no preg.

  // Dispatch only while ack is low, so a held req renames once.
  assign dispatch = req_i && (state_q != ACK) && can_go;

  assign wr_en_o   = dispatch && dest_live;
  assign pop_o     = dispatch && dest_live;  // Pop goes with every write.
  assign wr_preg_o = head_preg_i;

  assign ack_o = (state_q == ACK);  // Straight from the state register.
  assign rsp_o = rsp_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = dispatch ? ACK : WAIT_FREE;
        end
      end
      WAIT_FREE: begin
        if (dispatch) begin
          state_d = ACK;            // A retire refilled the list.
        end else if (!req_i) begin
          state_d = IDLE;           // Decoder withdrew the request.
        end
      end
      ACK: begin
        if (!req_i) begin
          state_d = IDLE;           // Fourth phase, ack drops.
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      if (dispatch) begin
        rsp_q.opa_preg  <= opa_preg_i;
        rsp_q.opa_rdy   <= opa_rdy_i;   // Already includes the CDB bypass.
        rsp_q.opb_preg  <= opb_preg_i;
        rsp_q.opb_rdy   <= opb_rdy_i;
        rsp_q.dest_preg <= dest_live ? head_preg_i : '0;
        rsp_q.old_preg  <= dest_live ? old_preg_i : '0;  // Nothing to free.
      end
    end
  end

endmodule

`default_nettype wire

/* src/rename_pkg.sv */
/*
 * Shared definitions for the register-renaming stage.
 * Register widths, free-list sizing, the decoder request and rename
 * response structs, and the broadcast struct used for CDB wakeup and
 * retirement. Every RTL module imports this package.
 */
`default_nettype none

package rename_pkg;

  localparam int NUM_AREGS  = 32;  // Architectural registers.
  localparam int NUM_PREGS  = 64;  // Physical registers.
  localparam int FREE_DEPTH = 32;  // Free-list capacity.

  typedef logic [4:0] areg_t;      // Architectural register index.
  typedef logic [5:0] preg_t;      // Physical register name.
  typedef logic [5:0] fl_count_t;  // Free-list occupancy, 0 to 32.

  // One instruction from the decoder.
  typedef struct packed {
    areg_t opa_areg;   // Source operand A.
    areg_t opb_areg;   // Source operand B.
    areg_t dest_areg;  // Destination, 0 means no write.
  } rename_req_t;

  // Registered rename result.
  typedef struct packed {
    preg_t opa_preg;
    logic  opa_rdy;
    preg_t opb_preg;
    logic  opb_rdy;
    preg_t dest_preg;  // New allocation, or 0 for no destination.
    preg_t old_preg;   // Prior mapping, freed later by the ROB.
  } rename_rsp_t;

  // A single physical register broadcast.
  typedef struct packed {
    logic  valid;
    preg_t preg;
  } preg_bcast_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE,       // Waiting for req.
    WAIT_FREE,  // Request held, free list empty.
    ACK         // Response valid, waiting for req to drop.
  } ren_state_t;

endpackage

`default_nettype wire

/* src/rename_top.sv */
/*
 * Top of the rename stage.
 * The map table and free list sit side by side; the controller combines
 * their outputs into one response per decoder handshake. CDB wakeups go
 * to the map table and retirements to the free list.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         req_i,
  input  rename_req_t req_data_i,
  input  preg_bcast_t cdb_i,     // Result broadcast for wakeup.
  input  preg_bcast_t retire_i,  // Preg freed at retirement.
  output logic        ack_o,
  output rename_rsp_t rsp_o
);

  preg_t opa_preg;
  preg_t opb_preg;
  preg_t old_preg;
  preg_t head_preg;
  preg_t wr_preg;
  logic  opa_rdy;
  logic  opb_rdy;
  logic  empty;
  logic  wr_en;
  logic  pop;

  rename_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .opa_preg_i  (opa_preg),
    .opb_preg_i  (opb_preg),
    .old_preg_i  (old_preg),
    .head_preg_i (head_preg),
    .opa_rdy_i   (opa_rdy),
    .opb_rdy_i   (opb_rdy),
    .empty_i     (empty),
    .ack_o       (ack_o),
    .rsp_o       (rsp_o),
    .wr_en_o     (wr_en),
    .wr_preg_o   (wr_preg),
    .pop_o       (pop)
  );

  // Lookups are indexed directly by the held request.
  map_table u_map (
    .clk         (clk),
    .rst         (rst),
    .opa_areg_i  (req_data_i.opa_areg),
    .opb_areg_i  (req_data_i.opb_areg),
    .dest_areg_i (req_data_i.dest_areg),
    .wr_en_i     (wr_en),
    .wr_preg_i   (wr_preg),
    .cdb_i       (cdb_i),
    .opa_preg_o  (opa_preg),
    .opb_preg_o  (opb_preg),
    .old_preg_o  (old_preg),
    .opa_rdy_o   (opa_rdy),
    .opb_rdy_o   (opb_rdy)
  );

  free_list u_free (
    .clk         (clk),
    .rst         (rst),
    .pop_i       (pop),
    .retire_i    (retire_i),
    .head_preg_o (head_preg),
    .empty_o     (empty)
  );

endmodule

`default_nettype wire
